//--- rtl/flitLink.sv
`default_nettype none

interface flitLink import nocPkg::*; ();

  logic     req;
  flitIdT   flitId;
  flitDataT data;
  pktLenT   pktLen; // length of the latest head flit on this link.

  modport src (
    output req,
    output flitId,
    output data,
    output pktLen
  );

  modport arb (
    input req,
    input flitId,
    input pktLen
  );

  modport mux (
    input req,
    input flitId,
    input data
  );

endinterface

`default_nettype wire

//--- rtl/flitMux.sv
`default_nettype none

module flitMux import nocPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  grantT    grant,
  flitLink.mux     lLink,
  flitLink.mux     nLink,
  flitLink.mux     eLink,
  flitLink.mux     wLink,
  flitLink.mux     sLink,
  output logic     outValid,
  output flitIdT   outFlitId,
  output flitDataT outData
);

  logic     selReq;
  flitIdT   selId;
  flitDataT selData;

  always_comb
  begin
    selReq  = 1'b0; // idle selects nothing, so valid drops.
    selId   = '0;
    selData = '0;
    case (grant)
      GNT_L:
      begin
        selReq  = lLink.req;
        selId   = lLink.flitId;
        selData = lLink.data;
      end
      GNT_N:
      begin
        selReq  = nLink.req;
        selId   = nLink.flitId;
        selData = nLink.data;
      end
      GNT_E:
      begin
        selReq  = eLink.req;
        selId   = eLink.flitId;
        selData = eLink.data;
      end
      GNT_W:
      begin
        selReq  = wLink.req;
        selId   = wLink.flitId;
        selData = wLink.data;
      end
      GNT_S:
      begin
        selReq  = sLink.req;
        selId   = sLink.flitId;
        selData = sLink.data;
      end
      default:
      begin
        selReq = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid  <= 1'b0;
      outFlitId <= '0;
      outData   <= '0;
    end
    else
    begin
      outValid  <= selReq;
      outFlitId <= selId;
      outData   <= selData;
    end
  end

endmodule

`default_nettype wire

//--- rtl/holdTimer.sv
`default_nettype none

module holdTimer import nocPkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   runTimer,
  input  pktLenT pktLen,
  output logic   timesUp
);

  pktLenT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0; // any cycle outside the grant restarts the count.
    end
  end

  // A grant that started at count zero has lasted pktLen plus one cycles here.
  assign timesUp = (count == pktLen);

endmodule

`default_nettype wire

//--- rtl/inputStage.sv
`default_nettype none

module inputStage import nocPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  input  flitIdT   flitId,
  input  flitDataT data,
  flitLink.src     link
);

  // Request, flit type and length are control state.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      link.req    <= 1'b0;
      link.flitId <= '0;
      link.pktLen <= '0;
    end
    else
    begin
      link.req    <= req;
      link.flitId <= flitId;
      if (flitId == FLIT_HEAD)
      begin
        link.pktLen <= data[11:0]; // length lives in the low bits of the head flit.
      end
    end
  end

  always_ff @(posedge clk)
  begin
    link.data <= data;
  end

endmodule

`default_nettype wire

//--- rtl/nocPkg.sv
`default_nettype none

package nocPkg;

  localparam int NUM_PORTS = 5;

  typedef logic [2:0] flitIdT;
  typedef logic [31:0] flitDataT;
  typedef logic [11:0] pktLenT; // hold time in cycles, from the head flit.
  typedef logic [5:0] grantT;

  localparam flitIdT FLIT_HEAD = 3'b001;
  localparam flitIdT FLIT_BODY = 3'b010;
  localparam flitIdT FLIT_TAIL = 3'b100;

  // Bit 0 is idle. Bits 1 to 5 grant L, N, E, W and S.
  typedef enum grantT {
    IDLE  = 6'b000001,
    GNT_L = 6'b000010,
    GNT_N = 6'b000100,
    GNT_E = 6'b001000,
    GNT_W = 6'b010000,
    GNT_S = 6'b100000
  } arbStateT;

endpackage

`default_nettype wire

//--- rtl/outputArbiter.sv
`default_nettype none

module outputArbiter import nocPkg::*; (
  input  logic  clk,
  input  logic  rst,
  flitLink.arb  lLink,
  flitLink.arb  nLink,
  flitLink.arb  eLink,
  flitLink.arb  wLink,
  flitLink.arb  sLink,
  output grantT grant
);

  arbStateT             state;
  arbStateT             stateNext;
  logic [NUM_PORTS-1:0] reqV;
  logic [NUM_PORTS-1:0] timesUp;
  logic [NUM_PORTS-1:0] runTimer;
  logic [2:0]           servedIdx;

  // First requester found from index first onward, looking at tries inputs.
  function automatic arbStateT pickNext(
    input logic [NUM_PORTS-1:0] reqs,
    input int                   first,
    input int                   tries
  );
    arbStateT pick;
    int       idx;
    pick = IDLE;
    for (int k = tries - 1; k >= 0; k--)
    begin
      idx = (first + k) % NUM_PORTS;
      if (reqs[idx])
      begin
        pick = arbStateT'(grantT'(1) << (idx + 1)); // lowest k wins.
      end
    end
    return pick;
  endfunction

  assign reqV = {sLink.req, wLink.req, eLink.req, nLink.req, lLink.req};

  holdTimer lTimer (.clk(clk), .rst(rst), .runTimer(runTimer[0]),
                    .pktLen(lLink.pktLen), .timesUp(timesUp[0]));
  holdTimer nTimer (.clk(clk), .rst(rst), .runTimer(runTimer[1]),
                    .pktLen(nLink.pktLen), .timesUp(timesUp[1]));
  holdTimer eTimer (.clk(clk), .rst(rst), .runTimer(runTimer[2]),
                    .pktLen(eLink.pktLen), .timesUp(timesUp[2]));
  holdTimer wTimer (.clk(clk), .rst(rst), .runTimer(runTimer[3]),
                    .pktLen(wLink.pktLen), .timesUp(timesUp[3]));
  holdTimer sTimer (.clk(clk), .rst(rst), .runTimer(runTimer[4]),
                    .pktLen(sLink.pktLen), .timesUp(timesUp[4]));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= stateNext;
    end
  end

  assign grant = state;

  always_comb
  begin
    servedIdx = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i + 1])
      begin
        servedIdx = 3'(i);
      end
    end
  end

  always_comb
  begin
    runTimer  = '0;
    stateNext = IDLE;
    case (state)
      IDLE:
      begin
        stateNext = pickNext(reqV, 0, NUM_PORTS); // fixed order L, N, E, W, S.
      end
      GNT_L, GNT_N, GNT_E, GNT_W, GNT_S:
      begin
        if (reqV[servedIdx] && !timesUp[servedIdx])
        begin
          runTimer[servedIdx] = 1'b1;
          stateNext           = state;
        end
        else
        begin
          // search the other four, starting after the one just served.
          stateNext = pickNext(reqV, int'(servedIdx) + 1, NUM_PORTS - 1);
        end
      end
      default:
      begin
        stateNext = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/outputPortTop.sv
`default_nettype none

module outputPortTop import nocPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     lReq,
  input  flitIdT   lFlitId,
  input  flitDataT lData,
  input  logic     nReq,
  input  flitIdT   nFlitId,
  input  flitDataT nData,
  input  logic     eReq,
  input  flitIdT   eFlitId,
  input  flitDataT eData,
  input  logic     wReq,
  input  flitIdT   wFlitId,
  input  flitDataT wData,
  input  logic     sReq,
  input  flitIdT   sFlitId,
  input  flitDataT sData,
  output grantT    outGrant,
  output logic     outValid,
  output flitIdT   outFlitId,
  output flitDataT outData
);

  flitLink lLink ();
  flitLink nLink ();
  flitLink eLink ();
  flitLink wLink ();
  flitLink sLink ();

  inputStage lStage (.clk(clk), .rst(rst), .req(lReq), .flitId(lFlitId), .data(lData),
                     .link(lLink.src));
  inputStage nStage (.clk(clk), .rst(rst), .req(nReq), .flitId(nFlitId), .data(nData),
                     .link(nLink.src));
  inputStage eStage (.clk(clk), .rst(rst), .req(eReq), .flitId(eFlitId), .data(eData),
                     .link(eLink.src));
  inputStage wStage (.clk(clk), .rst(rst), .req(wReq), .flitId(wFlitId), .data(wData),
                     .link(wLink.src));
  inputStage sStage (.clk(clk), .rst(rst), .req(sReq), .flitId(sFlitId), .data(sData),
                     .link(sLink.src));

  // grant comes straight from the state register.
  outputArbiter arbiter (
    .clk   (clk),
    .rst   (rst),
    .lLink (lLink.arb),
    .nLink (nLink.arb),
    .eLink (eLink.arb),
    .wLink (wLink.arb),
    .sLink (sLink.arb),
    .grant (outGrant)
  );

  flitMux mux (
    .clk       (clk),
    .rst       (rst),
    .grant     (outGrant),
    .lLink     (lLink.mux),
    .nLink     (nLink.mux),
    .eLink     (eLink.mux),
    .wLink     (wLink.mux),
    .sLink     (sLink.mux),
    .outValid  (outValid),
    .outFlitId (outFlitId),
    .outData   (outData)
  );

endmodule

`default_nettype wire

//--- src.f
rtl/nocPkg.sv
rtl/flitLink.sv
rtl/inputStage.sv
rtl/holdTimer.sv
rtl/outputArbiter.sv
rtl/flitMux.sv
rtl/outputPortTop.sv
testbench/outputPort_sva.sv
testbench/outputPortTb.sv

//--- testbench/outputPortTb.sv
`default_nettype none

module outputPortTb import nocPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CYCLES   = 23;
  localparam int FIELDS       = 18; // three per link, then grant, valid and data.
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;

  logic        clk;
  logic        rst;
  logic        req [NUM_PORTS];
  flitIdT      flitId [NUM_PORTS];
  flitDataT    data [NUM_PORTS];
  grantT       outGrant;
  logic        outValid;
  flitIdT      outFlitId;
  flitDataT    outData;
  logic [31:0] stim [NUM_CYCLES * FIELDS];

  outputPortTop outputPortTop_inst (
    .clk(clk), .rst(rst),
    .lReq(req[0]), .lFlitId(flitId[0]), .lData(data[0]),
    .nReq(req[1]), .nFlitId(flitId[1]), .nData(data[1]),
    .eReq(req[2]), .eFlitId(flitId[2]), .eData(data[2]),
    .wReq(req[3]), .wFlitId(flitId[3]), .wData(data[3]),
    .sReq(req[4]), .sFlitId(flitId[4]), .sData(data[4]),
    .outGrant(outGrant), .outValid(outValid), .outFlitId(outFlitId), .outData(outData)
  );

  bind outputArbiter outputPort_sva arbChecks (
    .clk    (clk),
    .rst    (rst),
    .grant  (grant),
    .pktLen ({sLink.pktLen, wLink.pktLen, eLink.pktLen, nLink.pktLen, lLink.pktLen})
  );

  initial
  begin
    clk = 1'b0;
  end

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stopWithFailure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic checkGrant(input int line, input grantT actual, input grantT expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t outGrant: got %b, expected %b (line %0d)",
               $time, actual, expected, line);
      stopWithFailure();
    end
  endtask

  task automatic checkValid(input int line, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t outValid: got %b, expected %b (line %0d)",
               $time, actual, expected, line);
      stopWithFailure();
    end
  endtask

  task automatic checkData(input int line, input flitDataT actual, input flitDataT expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t outData: got %h, expected %h (line %0d)",
               $time, actual, expected, line);
      stopWithFailure();
    end
  endtask

  task automatic checkFlitId(input int line, input flitIdT actual, input flitIdT expected);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t outFlitId: got %b, expected %b (line %0d)",
               $time, actual, expected, line);
      stopWithFailure();
    end
  endtask

  // flit type driven two lines back on the input granted one line back.
  function automatic flitIdT grantedFlitId(input int line);
    grantT  grantSeen;
    flitIdT id;
    grantSeen = stim[(line - 1) * FIELDS + 3 * NUM_PORTS][5:0];
    id        = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grantSeen[p + 1])
      begin
        id = stim[(line - 2) * FIELDS + 3 * p + 1][2:0];
      end
    end
    return id;
  endfunction

  task automatic compareLine(input int line);
    int base;
    base = line * FIELDS + 3 * NUM_PORTS;
    checkGrant(line, outGrant, stim[base][5:0]);
    checkValid(line, outValid, stim[base + 1][0]);
    if (stim[base + 1][0])
    begin
      checkData(line, outData, stim[base + 2]);
      checkFlitId(line, outFlitId, grantedFlitId(line));
    end
  endtask

  task automatic applyLine(input int line);
    int base;
    base = line * FIELDS;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p]    = stim[base + 3 * p][0];
      flitId[p] = stim[base + 3 * p + 1][2:0];
      data[p]   = stim[base + 3 * p + 2];
    end
  endtask

  initial
  begin
    rst = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      req[p]    = 1'b0;
      flitId[p] = '0;
      data[p]   = '0;
    end
    $readmemh("testbench/outputPort_stimulus.txt", stim);
    if ($isunknown(stim[NUM_CYCLES * FIELDS - 1]))
    begin
      $display("stimulus file is missing or shorter than expected");
      stopWithFailure();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      compareLine(c); // outputs registered at this edge.
      applyLine(c);
      @(posedge clk);
      #1;
    end
    if (outputPortTop_inst.arbiter.arbChecks.failCount == 0)
    begin
      $display("TEST RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("arbiter assertions failed %0d times",
               outputPortTop_inst.arbiter.arbChecks.failCount);
      stopWithFailure();
    end
  end

  initial
  begin
    wait (outputPortTop_inst.arbiter.arbChecks.failCount != 0);
    $display("an assertion on the arbiter failed");
    stopWithFailure();
  end

  initial
  begin
    #(NUM_CYCLES * CLK_PERIOD * 2);
    $display("watchdog timeout: the stimulus did not finish in time");
    stopWithFailure();
  end

endmodule

`default_nettype wire

//--- testbench/outputPort_stimulus.txt
// per link in order L N E W S: req flitId data, then expected outGrant outValid outData
// one line per clock after reset; outData is only compared where outValid is expected high
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 01 0 000
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 01 0 000
0 0 000 1 2 b02 0 0 000 0 0 000 0 0 000 01 0 000
0 0 000 1 2 b03 0 0 000 0 0 000 0 0 000 01 0 000
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 04 0 000
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 01 1 b03
1 2 a06 1 2 b06 1 2 c06 1 2 d06 1 2 e06 01 0 000
1 2 a07 1 2 b07 1 2 c07 1 2 d07 1 2 e07 01 0 000
1 2 a08 1 2 b08 1 2 c08 1 2 d08 1 2 e08 02 0 000
1 2 a09 1 2 b09 1 2 c09 1 2 d09 1 2 e09 04 1 a07
1 2 a0a 1 2 b0a 1 2 c0a 1 2 d0a 1 2 e0a 08 1 b08
1 2 a0b 1 2 b0b 1 2 c0b 1 2 d0b 1 2 e0b 10 1 c09
1 1 003 0 0 000 0 0 000 0 0 000 0 0 000 20 1 d0a
1 2 a0d 0 0 000 1 1 003 0 0 000 0 0 000 02 1 e0b
1 2 a0e 0 0 000 1 2 c0e 0 0 000 0 0 000 02 1 003
1 2 a0f 0 0 000 1 2 c0f 0 0 000 0 0 000 02 1 a0d
0 0 000 0 0 000 1 2 c10 1 1 003 0 0 000 02 1 a0e
0 0 000 0 0 000 0 0 000 1 2 d11 0 0 000 08 1 a0f
0 0 000 0 0 000 0 0 000 1 2 d12 0 0 000 08 1 c10
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 10 0 000
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 10 1 d12
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 01 0 000
0 0 000 0 0 000 0 0 000 0 0 000 0 0 000 01 0 000

//--- testbench/outputPort_sva.sv
`default_nettype none

module outputPort_sva import nocPkg::*; (
  input logic                   clk,
  input logic                   rst,
  input grantT                  grant,
  input pktLenT [NUM_PORTS-1:0] pktLen
);

  timeunit 1ns;
  timeprecision 100ps;

  int     failCount = 0; // assertions that have failed so far.
  grantT  prevGrant;
  int     heldBefore; // cycles the grant had already lasted at the previous clock.
  pktLenT servedLen;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      prevGrant  <= IDLE;
      heldBefore <= 0;
    end
    else
    begin
      prevGrant  <= grant;
      heldBefore <= (grant == prevGrant) ? heldBefore + 1 : 1;
    end
  end

  always_comb
  begin
    servedLen = '0;
    for (int i = 0; i < NUM_PORTS; i++)
    begin
      if (grant[i + 1])
      begin
        servedLen = pktLen[i];
      end
    end
  end

  oneHotGrant: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
  else
  begin
    failCount++;
    $error("grant is not one-hot: %b", grant);
  end

  idleAfterReset: assert property (@(posedge clk) rst |=> grant == IDLE)
  else
  begin
    failCount++;
    $error("grant is not idle in the cycle after reset: %b", grant);
  end

  // a grant lasts at most pktLen plus one cycles of the input it serves.
  holdLimit: assert property (@(posedge clk) disable iff (rst)
    (grant != IDLE && grant == prevGrant) |-> heldBefore <= int'(servedLen))
  else
  begin
    failCount++;
    $error("grant %b held longer than pktLen plus one cycles", grant);
  end

endmodule

`default_nettype wire
